// File: mpuHost.f
verilog/mpuPkg.sv
verilog/hostStream.sv
verilog/hostCommand.sv
verilog/threadMemory.sv
verilog/dataMemory.sv
verilog/mpuTop.sv
tb/mpuChecker.sv
tb/mpuTopTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -Wno-fatal --top-module mpuTopTb -f mpuHost.f -o mpuSim || exit 1
out=$(./obj_dir/mpuSim)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

// File: tb/mpuTopTb.sv
// expected status in the table leaves out the run bit, which depends on the random commit.
`timescale 1ns/100ps

module mpuTopTb
	import mpuPkg::*;
();

	typedef struct packed {
		word_t					data;
		logic					last;
		logic					check;		// compare status when taken.
		logic [NumStatus-1:0]	status;
	} stimRow_t;

	logic					clock = 1'b0;
	logic					reset;
	logic					inValid;
	logic					inReady;
	word_t					inData;
	logic					inLast;
	logic					outValid;
	logic					outReady = 1'b0;
	word_t					outData;
	logic					outLast;
	logic					dispatchValid;
	logic					dispatchReady = 1'b0;
	threadId_t				dispatchThread;
	progLen_t				dispatchLength;
	logic					commit = 1'b0;
	threadId_t				fetchThread = '0;
	progAddr_t				fetchAddress = '0;
	instr_t					fetchInstr;
	logic [NumStatus-1:0]	status;
	logic					expectCheck;
	logic [NumStatus-1:0]	expectStatus;
	logic					sweep = 1'b0;
	logic					tableReady = 1'b0;
	logic [$bits(threadId_t)+$bits(progAddr_t)-1:0]	fetchIndex = '0;
	stimRow_t				stim [$];
	int						errorCount;
	int						pendingCount;

	mpuTop dut (
		.clock, .reset, .inValid, .inReady, .inData, .inLast,
		.outValid, .outReady, .outData, .outLast,
		.dispatchValid, .dispatchReady, .dispatchThread, .dispatchLength,
		.commit, .fetchThread, .fetchAddress, .fetchInstr, .status
	);

	mpuChecker scoreboard (
		.clock, .reset, .inValid, .inReady, .inData, .inLast, .expectCheck, .expectStatus,
		.outValid, .outReady, .outData, .outLast,
		.dispatchValid, .dispatchReady, .dispatchThread, .dispatchLength,
		.commit, .fetchThread, .fetchAddress, .fetchInstr, .status, .errorCount, .pendingCount
	);

	initial begin
		forever #50 clock = ~clock;
	end

	function automatic word_t fillWord(input int address);
		return (address * 32'h0101_0101) ^ 32'h5A5A_0000;
	endfunction

	task automatic addWord(input word_t data, input logic last);
		stim.push_back({data, last, 1'b0, 4'b0000});
	endtask

	// status order is NoThread, Stop, Run, Ready.
	task automatic addCommand(input word_t data, input logic [NumStatus-1:0] expected);
		stim.push_back({data, 1'b0, 1'b1, expected});
	endtask

	task automatic addLoad(input word_t stride, input word_t base, input word_t count);
		addCommand(32'h8, 4'b0001);
		addWord(stride, 1'b0);
		addWord(base, 1'b0);
		addWord(count, 1'b1);
	endtask

	task automatic buildTable();
		addCommand(32'h2, 4'b0000);
		addWord(32'hFFFF_FFF1, 1'b0);		// slot 1 from the low bits.
		for (int i = 0; i < 5; i++)
			addWord(32'hA100_0000 + i, i == 4);
		addCommand(32'h2, 4'b0001);
		addWord(32'h2, 1'b0);
		for (int i = 0; i < 20; i++)
			addWord($urandom, i == 19);		// overflows the slot.
		addCommand(32'h1, 4'b0001);
		addWord(32'h11, 1'b1);
		addCommand(32'h1, 4'b0001);
		addWord(32'h3, 1'b1);				// absent slot.
		addCommand(32'h4, 4'b1001);
		addWord(32'h1, 1'b0);
		addWord(32'h0, 1'b0);
		for (int a = 0; a < DataDepth; a++)
			addWord(fillWord(a), a == DataDepth - 1);
		addCommand(32'h4, 4'b0001);
		addWord(32'h5, 1'b0);
		addWord(32'd60, 1'b0);				// walk wraps past the top.
		for (int i = 0; i < 10; i++)
			addWord($urandom, i == 9);
		addLoad(32'h5, 32'd60, 32'd12);
		addLoad(32'h3, 32'h7, 32'd25);
		addLoad(32'h1, 32'h0, 32'h0);
		addCommand(32'h100, 4'b0001);
		addCommand(32'h6, 4'b0000);
		addCommand(32'h16, 4'b0000);		// stop among other bits.
		addCommand(32'h2, 4'b0100);
		addCommand(32'h8, 4'b0100);
		addCommand(32'h0, 4'b0100);
		addCommand(32'h1, 4'b0100);
		addWord(32'h2, 1'b1);
		addCommand(32'h2, 4'b0001);
		addWord(32'h0, 1'b1);				// empty program.
		addCommand(32'h1, 4'b0001);
		addWord(32'h0, 1'b1);
		addLoad(32'h1, 32'h0, DataDepth);
	endtask

	// ##########################################################################
	// random back-pressure, commit and fetch addresses.
	always @(posedge clock) begin
		outReady <= ($urandom_range(1) == 1);
		dispatchReady <= ($urandom_range(3) != 0);
		commit <= ($urandom_range(7) == 0);
		if (sweep) begin
			{fetchThread, fetchAddress} <= fetchIndex;
			fetchIndex <= fetchIndex + 1'b1;
		end
		else begin
			fetchThread <= threadId_t'($urandom_range(NumThreads - 1));
			fetchAddress <= progAddr_t'($urandom_range(ProgDepth - 1));
		end
	end

	initial begin
		void'($urandom(32'h9237_ca8c));
		reset <= 1'b1;
		inValid <= 1'b0;
		inData <= '0;
		inLast <= 1'b0;
		expectCheck <= 1'b0;
		expectStatus <= '0;
		buildTable();
		tableReady = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		foreach (stim[i]) begin
			while ($urandom_range(3) == 0) begin
				@(posedge clock);
				inValid <= 1'b0;
			end
			@(posedge clock);
			inValid <= 1'b1;
			inData <= stim[i].data;
			inLast <= stim[i].last;
			expectCheck <= stim[i].check;
			expectStatus <= stim[i].status;
			@(negedge clock);
			while (!inReady) @(negedge clock);
		end
		@(posedge clock);
		inValid <= 1'b0;
		@(negedge clock);
		while (!status[StatusReady]) @(negedge clock);
		sweep = 1'b1;
		repeat (NumThreads*ProgDepth + 4) @(posedge clock);
		if (pendingCount != 0)
			$display("some expected load words or dispatches never arrived");
		$display("errors: %0d, missing outputs: %0d", errorCount, pendingCount);
		if (errorCount == 0 && pendingCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		wait (tableReady);
		repeat (stim.size() * 40) @(posedge clock);
		$display("the run timed out after %0d cycles", stim.size() * 40);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb/mpuChecker.sv
// compares at the falling edge; fetch is only checked for instruction words that were stored.
`timescale 1ns/100ps

module mpuChecker
	import mpuPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic					inValid,
	input	logic					inReady,
	input	word_t					inData,
	input	logic					inLast,
	input	logic					expectCheck,
	input	logic [NumStatus-1:0]	expectStatus,
	input	logic					outValid,
	input	logic					outReady,
	input	word_t					outData,
	input	logic					outLast,
	input	logic					dispatchValid,
	input	logic					dispatchReady,
	input	threadId_t				dispatchThread,
	input	progLen_t				dispatchLength,
	input	logic					commit,
	input	threadId_t				fetchThread,
	input	progAddr_t				fetchAddress,
	input	instr_t					fetchInstr,
	input	logic [NumStatus-1:0]	status,
	output	int						errorCount,
	output	int						pendingCount
);

	typedef enum {
		WaitCommand, WaitStopped, WaitThread, WaitSlot, WaitInstr,
		WaitStride, WaitBase, WaitData, WaitCount
	} modelState_e;

	modelState_e	modelState;
	instr_t			progModel [NumThreads*ProgDepth];
	logic			progKnown [NumThreads*ProgDepth];
	progLen_t		lengthModel [NumThreads];
	logic			presentModel [NumThreads];
	word_t			dataModel [DataDepth];
	word_t			loadQueue [$];
	logic			lastQueue [$];
	logic [$bits(threadId_t)+$bits(progLen_t)-1:0]	dispatchQueue [$];
	logic			isLoad;
	threadId_t		slot;
	int				wordIndex;
	dataAddr_t		stride;
	dataAddr_t		address;
	logic			runModel;
	instr_t			fetchExpect;
	logic			fetchKnown;
	int				errors = 0;

	assign errorCount = errors;

	task automatic reportError(input string message);
		errors++;
		$display("ERR %0t: %s", $time, message);
	endtask

	// ##########################################################################
	// reference model steps one host word at a time.
	task automatic takeWord(input word_t data, input logic last);
		threadId_t			id;
		logic [NumCmds-1:0]	bits;
		int					count;
		id = data[$bits(threadId_t)-1:0];
		bits = data[NumCmds-1:0];
		case (modelState)
			WaitCommand: begin
				if (bits[CmdStop])
					modelState = WaitStopped;
				else if ($countones(bits) != 1)
					modelState = WaitCommand;		// dropped.
				else if (bits[CmdRun])
					modelState = WaitThread;
				else if (bits[CmdStoreProg])
					modelState = WaitSlot;
				else begin
					isLoad = bits[CmdLoadData];
					modelState = WaitStride;
				end
			end
			WaitStopped: if (data[CmdRun]) modelState = WaitThread;
			WaitThread: begin
				if (presentModel[id])
					dispatchQueue.push_back({id, lengthModel[id]});
				modelState = WaitCommand;
			end
			WaitSlot: begin
				slot = id;
				wordIndex = 0;
				if (last) begin
					presentModel[id] = 1'b1;		// empty program.
					lengthModel[id] = '0;
					modelState = WaitCommand;
				end
				else
					modelState = WaitInstr;
			end
			WaitInstr: begin
				if (wordIndex < ProgDepth) begin
					progModel[slot*ProgDepth + wordIndex] = data;
					progKnown[slot*ProgDepth + wordIndex] = 1'b1;
					wordIndex++;
				end
				if (last) begin
					presentModel[slot] = 1'b1;
					lengthModel[slot] = progLen_t'(wordIndex);
					modelState = WaitCommand;
				end
			end
			WaitStride: begin
				stride = data[$bits(dataAddr_t)-1:0];
				modelState = WaitBase;
			end
			WaitBase: begin
				address = data[$bits(dataAddr_t)-1:0];
				modelState = isLoad ? WaitCount : WaitData;
			end
			WaitData: begin
				dataModel[address] = data;
				address = address + stride;		// modulo the depth.
				if (last)
					modelState = WaitCommand;
			end
			default: begin
				count = int'(data[$bits(dataCount_t)-1:0]);
				for (int i = 0; i < count; i++) begin
					loadQueue.push_back(dataModel[address]);
					lastQueue.push_back(i == count - 1);
					address = address + stride;
				end
				modelState = WaitCommand;
			end
		endcase
	endtask

	always @(negedge clock) begin
		logic [NumStatus-1:0]	mask;
		int						index;
		mask = '1;
		mask[StatusRun] = 1'b0;
		if (reset) begin
			modelState = WaitCommand;
			runModel = 1'b0;
			fetchKnown = 1'b0;
			for (int i = 0; i < NumThreads*ProgDepth; i++)
				progKnown[i] = 1'b0;
			for (int i = 0; i < NumThreads; i++)
				presentModel[i] = 1'b0;
			loadQueue.delete();
			lastQueue.delete();
			dispatchQueue.delete();
		end
		else begin
			if (fetchKnown && fetchInstr !== fetchExpect)
				reportError($sformatf("fetch read %h, expected %h", fetchInstr, fetchExpect));
			index = int'(fetchThread) * ProgDepth + int'(fetchAddress);
			fetchExpect = progModel[index];		// read lands next cycle.
			fetchKnown = progKnown[index];
			if (status[StatusRun] !== runModel)
				reportError($sformatf("run flag %b, expected %b", status[StatusRun], runModel));
			if (commit)
				runModel = 1'b0;
			else if (dispatchValid && dispatchReady)
				runModel = 1'b1;
			if (dispatchValid && dispatchReady) begin
				if (dispatchQueue.size() == 0)
					reportError($sformatf("dispatch of thread %0d with no run pending",
						dispatchThread));
				else if ({dispatchThread, dispatchLength} !== dispatchQueue.pop_front())
					reportError($sformatf("dispatch thread %0d length %0d is wrong",
						dispatchThread, dispatchLength));
			end
			if (outValid && outReady) begin
				if (loadQueue.size() == 0)
					reportError($sformatf("load word %h with no load pending", outData));
				else if (outData !== loadQueue[0] || outLast !== lastQueue[0])
					reportError($sformatf("load word %h last %b, expected %h last %b",
						outData, outLast, loadQueue[0], lastQueue[0]));
				if (loadQueue.size() != 0) begin
					void'(loadQueue.pop_front());
					void'(lastQueue.pop_front());
				end
			end
			if (inValid && inReady && expectCheck && (status & mask) !== (expectStatus & mask))
				reportError($sformatf("status %b at command %h, expected %b with run ignored",
					status, inData, expectStatus));
			if (inValid && inReady)
				takeWord(inData, inLast);
		end
		pendingCount = loadQueue.size() + dispatchQueue.size();
	end

endmodule

// File: verilog/mpuTop.sv
// run ends at the dispatch port; an external commit clears the run flag.
`timescale 1ns/100ps

module mpuTop
	import mpuPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic					inValid,
	output	logic					inReady,
	input	word_t					inData,
	input	logic					inLast,
	output	logic					outValid,
	input	logic					outReady,
	output	word_t					outData,
	output	logic					outLast,
	output	logic					dispatchValid,
	input	logic					dispatchReady,
	output	threadId_t				dispatchThread,
	output	progLen_t				dispatchLength,
	input	logic					commit,
	input	threadId_t				fetchThread,
	input	progAddr_t				fetchAddress,
	output	instr_t					fetchInstr,
	output	logic [NumStatus-1:0]	status
);

	logic		queryValid;
	threadId_t	queryId;
	logic		queryDone;
	logic		queryPresent;
	progLen_t	queryLength;
	logic		jobStart;
	dataJob_t	jobInfo;
	logic		jobBusy;

	hostStream #(.payload_t(instr_t))	progStream ();
	hostStream #(.payload_t(word_t))	storeStream ();
	hostStream #(.payload_t(word_t))	loadStream ();

	// load stream out to the host.
	assign outValid				= loadStream.valid;
	assign outData				= loadStream.payload;
	assign outLast				= loadStream.last;
	assign loadStream.ready		= outReady;

	hostCommand command (
		.clock, .reset, .inValid, .inReady, .inData, .inLast,
		.progStream (progStream.sender), .storeStream (storeStream.sender),
		.queryValid, .queryId, .queryDone, .queryPresent, .queryLength,
		.jobStart, .jobInfo, .jobBusy,
		.dispatchValid, .dispatchReady, .dispatchThread, .dispatchLength,
		.commit, .status
	);

	threadMemory threads (
		.clock, .reset, .progStream (progStream.receiver),
		.queryValid, .queryId, .queryDone, .queryPresent, .queryLength,
		.fetchThread, .fetchAddress, .fetchInstr
	);

	dataMemory data (
		.clock, .reset, .jobStart, .jobInfo, .jobBusy,
		.storeStream (storeStream.receiver), .loadStream (loadStream.sender)
	);

endmodule

// File: verilog/dataMemory.sv
// stores and loads never overlap; store ready stays low while a load is in flight.
`timescale 1ns/100ps

module dataMemory
	import mpuPkg::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		jobStart,
	input	dataJob_t	jobInfo,
	output	logic		jobBusy,
	hostStream.receiver	storeStream,
	hostStream.sender	loadStream
);

	word_t			dataMem [DataDepth];
	dataAddr_t		address;
	dataAddr_t		stride;
	dataCount_t		remaining;		// load words not yet read.
	logic			outValid;
	logic			storeTake;
	logic			advance;

	assign jobBusy				= (remaining != '0) | outValid;
	assign storeStream.ready	= ~jobBusy;
	assign storeTake			= storeStream.valid & storeStream.ready;
	assign advance				= (remaining != '0) & (~outValid | loadStream.ready);
	assign loadStream.valid		= outValid;

	always_ff @(posedge clock) begin
		if (reset) begin
			remaining	<= '0;
			outValid	<= 1'b0;
		end
		else begin
			if (jobStart)
				remaining <= jobInfo.isLoad ? jobInfo.count : '0;
			else if (advance)
				remaining <= remaining - 1'b1;
			if (advance)
				outValid <= 1'b1;
			else if (loadStream.ready)
				outValid <= 1'b0;		// word taken with nothing behind it.
		end
	end

	// ##########################################################################
	// address walk and storage.
	always_ff @(posedge clock) begin
		if (jobStart) begin
			address	<= jobInfo.base;
			stride	<= jobInfo.stride;
		end
		else if (storeTake || advance) begin
			address <= address + stride;		// wraps.
		end
		if (storeTake)
			dataMem[address] <= storeStream.payload;
		if (advance) begin
			loadStream.payload	<= dataMem[address];
			loadStream.last		<= (remaining == dataCount_t'(1));
		end
	end

endmodule

// File: verilog/threadMemory.sv
// first word after a last selects the slot; words past the slot depth are dropped.
`timescale 1ns/100ps

module threadMemory
	import mpuPkg::*;
(
	input	logic		clock,
	input	logic		reset,
	hostStream.receiver	progStream,
	input	logic		queryValid,
	input	threadId_t	queryId,
	output	logic		queryDone,
	output	logic		queryPresent,
	output	progLen_t	queryLength,
	input	threadId_t	fetchThread,
	input	progAddr_t	fetchAddress,
	output	instr_t		fetchInstr
);

	instr_t					progMem [NumThreads*ProgDepth];
	progLen_t				progLength [NumThreads];
	logic [NumThreads-1:0]	present;
	logic					expectId;		// next word is a slot number.
	logic					take;
	threadId_t				slot;
	threadId_t				newSlot;
	progLen_t				writeLen;
	progLen_t				nextLen;
	logic					slotFull;

	assign progStream.ready	= 1'b1;
	assign take				= progStream.valid & progStream.ready;
	assign newSlot			= progStream.payload[$bits(threadId_t)-1:0];
	assign slotFull			= (writeLen == progLen_t'(ProgDepth));
	assign nextLen			= slotFull ? writeLen : writeLen + 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			expectId	<= 1'b1;
			present		<= '0;
			queryDone	<= 1'b0;
		end
		else begin
			queryDone <= queryValid;
			if (take && expectId) begin
				present[newSlot]	<= progStream.last;	// empty program if last.
				expectId			<= progStream.last;
			end
			else if (take && progStream.last) begin
				present[slot]	<= 1'b1;
				expectId		<= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take && expectId) begin
			slot		<= newSlot;
			writeLen	<= '0;
			if (progStream.last)
				progLength[newSlot] <= '0;
		end
		else if (take) begin
			if (!slotFull)
				progMem[{slot, writeLen[$bits(progAddr_t)-1:0]}] <= progStream.payload;
			writeLen <= nextLen;
			if (progStream.last)
				progLength[slot] <= nextLen;
		end
		queryPresent	<= present[queryId];
		queryLength		<= progLength[queryId];
		fetchInstr		<= progMem[{fetchThread, fetchAddress}];	// one-cycle read.
	end

endmodule

// File: verilog/hostCommand.sv
// one transaction at a time; a bad command word is dropped and only clears the ready flag.
`timescale 1ns/100ps

module hostCommand
	import mpuPkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic					inValid,
	output	logic					inReady,
	input	word_t					inData,
	input	logic					inLast,
	hostStream.sender				progStream,
	hostStream.sender				storeStream,
	output	logic					queryValid,
	output	threadId_t				queryId,
	input	logic					queryDone,
	input	logic					queryPresent,
	input	progLen_t				queryLength,
	output	logic					jobStart,
	output	dataJob_t				jobInfo,
	input	logic					jobBusy,
	output	logic					dispatchValid,
	input	logic					dispatchReady,
	output	threadId_t				dispatchThread,
	output	progLen_t				dispatchLength,
	input	logic					commit,
	output	logic [NumStatus-1:0]	status
);

	hostState_e				state;
	logic [NumCmds-1:0]		cmdBits;
	logic					take;
	logic					progTake;
	logic					storeTake;
	logic					absent;
	logic					ready;
	logic					run;
	logic					noThread;
	logic					setReady;
	logic					clrReady;
	threadId_t				runThread;
	progLen_t				runLength;
	dataAddr_t				jobStride;
	dataAddr_t				jobBase;

	always_comb begin
		case (state)
			Idle, Stopped, RunId, StoreStride, StoreBase,
			LoadStride, LoadBase, LoadCount:	inReady = 1'b1;
			ProgId, ProgWords:					inReady = progStream.ready;
			StoreWords:							inReady = storeStream.ready;
			default:							inReady = 1'b0;
		endcase
	end

	assign take = inValid & inReady;

	// ##########################################################################
	// stream words pass straight through.
	assign progStream.valid		= inValid & (state == ProgId || state == ProgWords);
	assign progStream.payload	= inData;
	assign progStream.last		= inLast;
	assign storeStream.valid	= inValid & (state == StoreWords);
	assign storeStream.payload	= inData;
	assign storeStream.last		= inLast;

	assign progTake		= progStream.valid & progStream.ready;
	assign storeTake	= storeStream.valid & storeStream.ready;

	assign jobStart = take & (state == StoreBase || state == LoadCount);

	always_comb begin
		jobInfo.stride	= jobStride;
		jobInfo.base	= (state == StoreBase) ? inData[$bits(dataAddr_t)-1:0] : jobBase;
		jobInfo.count	= inData[$bits(dataCount_t)-1:0];	// ignored on stores.
		jobInfo.isLoad	= (state == LoadCount);
	end

	assign queryId			= runThread;
	assign absent			= (state == RunQuery) & queryDone & ~queryPresent;
	assign dispatchValid	= (state == RunDispatch);
	assign dispatchThread	= runThread;
	assign dispatchLength	= runLength;

	// ##########################################################################
	// status flags.
	assign clrReady = (state == CheckCommand) | ((state == Stopped) & take & inData[CmdRun]);
	assign setReady = ((progTake | storeTake) & inLast) | ((state == LoadWords) & ~jobBusy)
		| absent | (dispatchValid & dispatchReady);

	always_ff @(posedge clock) begin
		if (reset) begin
			ready		<= 1'b0;
			run			<= 1'b0;
			noThread	<= 1'b0;
			queryValid	<= 1'b0;
		end
		else begin
			if (clrReady)
				ready <= 1'b0;
			else if (setReady)
				ready <= 1'b1;
			if (commit)
				run <= 1'b0;
			else if (dispatchValid & dispatchReady)
				run <= 1'b1;
			if (take & (state == Idle || state == Stopped))
				noThread <= 1'b0;		// any new command word.
			else if (absent)
				noThread <= 1'b1;
			queryValid <= (state == RunId) & take;		// one-cycle pulse.
		end
	end

	always_comb begin
		status					= '0;
		status[StatusReady]		= ready;
		status[StatusRun]		= run;
		status[StatusStop]		= (state == Stopped);
		status[StatusNoThread]	= noThread;
	end

	always_ff @(posedge clock) begin
		if (state == Idle && take)
			cmdBits <= inData[NumCmds-1:0];
		if (state == RunId && take)
			runThread <= inData[$bits(threadId_t)-1:0];
		if (state == RunQuery && queryDone)
			runLength <= queryLength;
		if ((state == StoreStride || state == LoadStride) && take)
			jobStride <= inData[$bits(dataAddr_t)-1:0];
		if (state == LoadBase && take)
			jobBase <= inData[$bits(dataAddr_t)-1:0];
	end

	// ##########################################################################
	// sequencer.
	always_ff @(posedge clock) begin
		if (reset)
			state <= Idle;
		else case (state)
			Idle:			if (take) state <= CheckCommand;
			CheckCommand: begin
				if (cmdBits[CmdStop])
					state <= Stopped;		// stop wins over the rest.
				else if (!$onehot(cmdBits))
					state <= Idle;
				else if (cmdBits[CmdRun])
					state <= RunId;
				else if (cmdBits[CmdStoreProg])
					state <= ProgId;
				else if (cmdBits[CmdStoreData])
					state <= StoreStride;
				else
					state <= LoadStride;
			end
			Stopped:		if (take && inData[CmdRun]) state <= RunId;
			RunId:			if (take) state <= RunQuery;
			RunQuery:		if (queryDone) state <= queryPresent ? RunDispatch : Idle;
			RunDispatch:	if (dispatchReady) state <= Idle;
			ProgId:			if (progTake) state <= inLast ? Idle : ProgWords;
			ProgWords:		if (progTake && inLast) state <= Idle;
			StoreStride:	if (take) state <= StoreBase;
			StoreBase:		if (take) state <= StoreWords;
			StoreWords:		if (storeTake && inLast) state <= Idle;
			LoadStride:		if (take) state <= LoadBase;
			LoadBase:		if (take) state <= LoadCount;
			LoadCount:		if (take) state <= LoadWords;
			LoadWords:		if (!jobBusy) state <= Idle;
			default:		state <= Idle;
		endcase
	end

endmodule

// File: verilog/hostStream.sv
// payload and last must hold steady while valid is high and ready is low.
`timescale 1ns/100ps

interface hostStream #(
	parameter type payload_t = logic [31:0]
);

	logic		valid;
	logic		ready;
	payload_t	payload;
	logic		last;		// final word of a transfer.

	modport sender (output valid, output payload, output last, input ready);

	modport receiver (input valid, input payload, input last, output ready);

endinterface

// File: verilog/mpuPkg.sv
// one data bank and four program slots; every address walk wraps modulo the memory depth.
package mpuPkg;

	// ##########################################################################
	// sizes
	localparam int WordWidth	= 32;
	localparam int NumThreads	= 4;
	localparam int ProgDepth	= 16;
	localparam int DataDepth	= 64;

	typedef logic [WordWidth-1:0]				word_t;
	typedef logic [WordWidth-1:0]				instr_t;
	typedef logic [$clog2(NumThreads)-1:0]		threadId_t;
	typedef logic [$clog2(ProgDepth)-1:0]		progAddr_t;
	typedef logic [$clog2(ProgDepth):0]		progLen_t;		// 0 to 16.
	typedef logic [$clog2(DataDepth)-1:0]		dataAddr_t;
	typedef logic [$clog2(DataDepth):0]		dataCount_t;

	// ##########################################################################
	// command word bits, one-hot.
	localparam int NumCmds		= 5;
	localparam int CmdRun		= 0;
	localparam int CmdStoreProg	= 1;
	localparam int CmdStoreData	= 2;
	localparam int CmdLoadData	= 3;
	localparam int CmdStop		= 4;

	// status bits.
	localparam int NumStatus		= 4;
	localparam int StatusReady		= 0;
	localparam int StatusRun		= 1;
	localparam int StatusStop		= 2;
	localparam int StatusNoThread	= 3;

	typedef enum logic [3:0] {
		Idle, CheckCommand, Stopped,
		RunId, RunQuery, RunDispatch,
		ProgId, ProgWords,
		StoreStride, StoreBase, StoreWords,
		LoadStride, LoadBase, LoadCount, LoadWords
	} hostState_e;

	typedef struct packed {
		dataAddr_t	base;
		dataAddr_t	stride;
		dataCount_t	count;		// loads only.
		logic		isLoad;
	} dataJob_t;

endpackage
